//--- sources.f
verilog/xbar_pkg.sv
verilog/read_arbiter.sv
verilog/addr_router.sv
verilog/clint.sv
verilog/xbar.sv
verilog/uncore_top.sv
testbench/tb_clock.sv
testbench/tb_soc_slave.sv
testbench/tb_top.sv

//--- Makefile
SRCS := $(wildcard verilog/*.sv testbench/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_top

obj_dir/Vtb_top: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_top -f sources.f

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top

clean:
	rm -rf obj_dir

//--- testbench/tb_top.sv
`timescale 1ns/100ps

module tb_top;

	import xbar_pkg::*;

	localparam logic [31:0] clint_base = 32'h0200_0000;
	localparam logic [31:0] clint_mask = 32'h0000_ffff;
	localparam int n_entries = 11;
	localparam int timeout_cycles = n_entries * 64 + 16;

	localparam logic [1:0] k_ifu   = 2'd0;
	localparam logic [1:0] k_lsu   = 2'd1;
	localparam logic [1:0] k_both  = 2'd2;
	localparam logic [1:0] k_write = 2'd3;

	typedef struct packed {
		logic [1:0]  kind;
		logic [31:0] addr;
		logic [2:0]  size;
		logic [31:0] wdata;
		logic [7:0]  strb;
		logic [1:0]  resp;
	} entry_t;

	logic clock;
	logic rst;
	addr_req_t ifu_ar, lsu_ar, lsu_aw, soc_ar, soc_aw;
	logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	logic [31:0] ifu_rdata;
	logic [1:0] ifu_rresp, lsu_bresp, soc_bresp;
	logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	r_resp_t lsu_r, soc_r;
	logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
	logic [31:0] lsu_wdata;
	logic [7:0] lsu_wstrb;
	logic soc_arvalid, soc_arready, soc_rvalid, soc_rready;
	logic soc_awvalid, soc_awready, soc_wvalid, soc_wready, soc_wlast;
	logic soc_bvalid, soc_bready;
	w_beat_t soc_w;

	entry_t stim[n_entries];
	logic [31:0] lfsr_state;
	int cycles = 0;
	int ifu_r_cyc, lsu_r_cyc, lsu_ar_cyc;
	logic in_clint = 1'b0;    // lsu read aimed at the clint
	logic [31:0] lo_q[$];
	logic [31:0] hi_q[$];

	tb_clock clk_i (.clock(clock), .rst(rst));

	uncore_top #(
		.clint_base (clint_base),
		.clint_mask (clint_mask)
	) dut_i (.*);

	tb_soc_slave soc_i (
		.clock(clock), .rst(rst),
		.ar(soc_ar), .arvalid(soc_arvalid), .arready(soc_arready),
		.r(soc_r), .rvalid(soc_rvalid), .rready(soc_rready),
		.aw(soc_aw), .awvalid(soc_awvalid), .awready(soc_awready),
		.w(soc_w), .wlast(soc_wlast), .wvalid(soc_wvalid), .wready(soc_wready),
		.bresp(soc_bresp), .bvalid(soc_bvalid), .bready(soc_bready)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [3:0] take_bits(input int n);
		logic [3:0] v;
		v = 4'h0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic abort_run;
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h exp %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic ifu_read(input logic [31:0] addr, input logic [3:0] hold,
			output logic [31:0] data, output logic [1:0] resp);
		logic [31:0] held;
		@(posedge clock);
		#2;
		ifu_ar.addr = addr;
		ifu_ar.size = 3'd2;
		ifu_arvalid = 1'b1;
		do @(negedge clock); while (!ifu_arready);
		@(posedge clock);
		#2;
		ifu_arvalid = 1'b0;
		do @(negedge clock); while (!ifu_rvalid);
		held = ifu_rdata;
		repeat (hold) begin
			@(negedge clock);
			check_eq("ifu_rvalid", {63'h0, ifu_rvalid}, 64'h1);
			check_eq("ifu_rdata", {32'h0, ifu_rdata}, {32'h0, held});
		end
		@(posedge clock);
		#2;
		ifu_rready = 1'b1;
		@(negedge clock);
		check_eq("ifu_rvalid", {63'h0, ifu_rvalid}, 64'h1);
		data = ifu_rdata;
		resp = ifu_rresp;
		ifu_r_cyc = cycles;
		@(posedge clock);
		#2;
		ifu_rready = 1'b0;
	endtask

	task automatic lsu_read(input logic [31:0] addr, input logic [3:0] hold, output r_resp_t rd);
		r_resp_t held;
		@(posedge clock);
		#2;
		lsu_ar.addr = addr;
		lsu_ar.size = 3'd2;
		lsu_arvalid = 1'b1;
		do @(negedge clock); while (!lsu_arready);
		lsu_ar_cyc = cycles;
		@(posedge clock);
		#2;
		lsu_arvalid = 1'b0;
		lsu_ar = '0;    // router must keep the latched target
		do @(negedge clock); while (!lsu_rvalid);
		held = lsu_r;
		repeat (hold) begin
			@(negedge clock);
			check_eq("lsu_rvalid", {63'h0, lsu_rvalid}, 64'h1);
			check_eq("lsu_r.data", lsu_r.data, held.data);
		end
		@(posedge clock);
		#2;
		lsu_rready = 1'b1;
		@(negedge clock);
		check_eq("lsu_rvalid", {63'h0, lsu_rvalid}, 64'h1);
		rd = lsu_r;
		lsu_r_cyc = cycles;
		@(posedge clock);
		#2;
		lsu_rready = 1'b0;
	endtask

	task automatic lsu_write(input entry_t e, output logic [1:0] resp);
		logic aw_done;
		logic w_done;
		@(posedge clock);
		#2;
		lsu_aw.addr = e.addr;
		lsu_aw.size = e.size;
		lsu_awvalid = 1'b1;
		lsu_wdata = e.wdata;
		lsu_wstrb = e.strb;
		lsu_wvalid = 1'b1;
		lsu_bready = 1'b1;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done)) begin
			@(negedge clock);
			if (lsu_awvalid && lsu_awready) aw_done = 1'b1;
			if (lsu_wvalid && lsu_wready) w_done = 1'b1;
			@(posedge clock);
			#2;
			if (aw_done) lsu_awvalid = 1'b0;
			if (w_done) lsu_wvalid = 1'b0;
		end
		do @(negedge clock); while (!lsu_bvalid);
		resp = lsu_bresp;
		@(posedge clock);
		#2;
		lsu_bready = 1'b0;
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("run timed out after %0d cycles", cycles);
			abort_run();
		end
	end

	// clint reads never reach the soc port
	always @(negedge clock) begin
		if (in_clint) begin
			assert (!soc_arvalid) else begin
				$display("ERR soc_arvalid got %h exp %h", soc_arvalid, 1'b0);
				abort_run();
			end
		end
	end

	initial begin
		entry_t e;
		logic [31:0] idata;
		logic [1:0] iresp;
		logic [1:0] bresp;
		r_resp_t rd;
		logic [3:0] h0, h1;
		logic [31:0] a2;
		stim[0]  = '{k_ifu,   32'h8000_0000, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[1]  = '{k_lsu,   32'h8000_1234, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[2]  = '{k_lsu,   32'h0200_bff8, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[3]  = '{k_lsu,   32'h0200_bffc, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[4]  = '{k_lsu,   32'h0200_bff8, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[5]  = '{k_lsu,   32'h0200_bffc, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[6]  = '{k_lsu,   32'h0200_0010, 3'd2, 32'h0, 8'h00, resp_slverr};
		stim[7]  = '{k_both,  32'h8000_0040, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[8]  = '{k_write, 32'h8000_2000, 3'd2, 32'hdead_beef, 8'h0f, resp_okay};
		stim[9]  = '{k_lsu,   32'h1000_0008, 3'd2, 32'h0, 8'h00, resp_okay};
		stim[10] = '{k_ifu,   32'h0000_0100, 3'd2, 32'h0, 8'h00, resp_okay};
		lfsr_state = 32'h69d1_95bc;
		ifu_ar = '0;
		ifu_arvalid = 1'b0;
		ifu_rready = 1'b0;
		lsu_ar = '0;
		lsu_arvalid = 1'b0;
		lsu_rready = 1'b0;
		lsu_aw = '0;
		lsu_awvalid = 1'b0;
		lsu_wdata = 32'h0;
		lsu_wstrb = 8'h0;
		lsu_wvalid = 1'b0;
		lsu_bready = 1'b0;
		while (rst !== 1'b0) @(posedge clock);

		for (int i = 0; i < n_entries; i++) begin
			e = stim[i];
			h0 = take_bits(2);
			h1 = take_bits(2);
			case (e.kind)
				k_ifu: begin
					ifu_read(e.addr, h0, idata, iresp);
					check_eq("ifu_rdata", {32'h0, idata}, {32'h0, e.addr});
					check_eq("ifu_rresp", {62'h0, iresp}, {62'h0, e.resp});
				end
				k_lsu: begin
					in_clint = e.addr[31:16] == 16'h0200;
					lsu_read(e.addr, h0, rd);
					in_clint = 1'b0;
					check_eq("lsu_r.resp", {62'h0, rd.resp}, {62'h0, e.resp});
					if (e.addr[31:16] != 16'h0200) begin
						check_eq("lsu_r.data", rd.data, {~e.addr, e.addr});
					end else if (e.resp == resp_slverr) begin
						check_eq("lsu_r.data", rd.data, 64'h0);
					end else begin
						check_eq("lsu_r.data[63:32]", {32'h0, rd.data[63:32]}, 64'h0);
						if (e.addr[15:0] == 16'hbff8) lo_q.push_back(rd.data[31:0]);
						else hi_q.push_back(rd.data[31:0]);
					end
				end
				k_both: begin
					a2 = e.addr + 32'h100;
					fork
						ifu_read(e.addr, h0, idata, iresp);
						lsu_read(a2, h1, rd);
					join
					check_eq("ifu_rdata", {32'h0, idata}, {32'h0, e.addr});
					check_eq("ifu_rresp", {62'h0, iresp}, {62'h0, e.resp});
					check_eq("lsu_r.data", rd.data, {~a2, a2});
					check_eq("lsu_r.resp", {62'h0, rd.resp}, {62'h0, e.resp});
					assert (ifu_r_cyc < lsu_r_cyc) else begin
						$display("lsu response arrived before the ifu response");
						abort_run();
					end
					assert (lsu_ar_cyc > ifu_r_cyc) else begin
						$display("lsu address was accepted before the ifu read completed");
						abort_run();
					end
				end
				default: begin
					lsu_write(e, bresp);
					check_eq("lsu_bresp", {62'h0, bresp}, {62'h0, e.resp});
					check_eq("soc_aw.addr", {32'h0, soc_i.last_awaddr}, {32'h0, e.addr});
					check_eq("soc_w.data", soc_i.last_wdata, {32'h0, e.wdata});
					check_eq("soc_w.strb", {56'h0, soc_i.last_wstrb}, {56'h0, e.strb});
					check_eq("soc_wlast", {63'h0, soc_i.last_wlast}, 64'h1);
				end
			endcase
		end

		// mtime_hi stays 0 in a run this short
		foreach (hi_q[i]) begin
			check_eq("mtime_hi", {32'h0, hi_q[i]}, 64'h0);
		end
		// mtime_lo must grow while mtime_hi holds
		for (int i = 1; i < lo_q.size(); i++) begin
			assert (lo_q[i] > lo_q[i-1]) else begin
				$display("ERR mtime_lo got %h exp above %h", lo_q[i], lo_q[i-1]);
				abort_run();
			end
		end
		$display("test passed");
		$finish;
	end

endmodule

//--- testbench/tb_soc_slave.sv
`timescale 1ns/100ps

module tb_soc_slave (
	input  logic                clock,
	input  logic                rst,
	input  xbar_pkg::addr_req_t ar,
	input  logic                arvalid,
	output logic                arready,
	output xbar_pkg::r_resp_t   r,
	output logic                rvalid,
	input  logic                rready,
	input  xbar_pkg::addr_req_t aw,
	input  logic                awvalid,
	output logic                awready,
	input  xbar_pkg::w_beat_t   w,
	input  logic                wlast,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready
);

	import xbar_pkg::*;

	logic [31:0] lfsr_state;
	logic [31:0] last_awaddr;
	logic [63:0] last_wdata;
	logic [7:0]  last_wstrb;
	logic        last_wlast;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [3:0] take_bits(input int n);
		logic [3:0] v;
		v = 4'h0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// read side handles one beat per request
	initial begin
		logic [31:0] addr;
		logic [3:0]  delay;
		lfsr_state = 32'h69d1_95bc;
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		forever begin
			@(posedge clock);
			#2;
			if (!rst) begin
				delay = take_bits(2);
				repeat (delay) begin
					@(posedge clock);
					#2;
				end
				arready = 1'b1;
				do @(negedge clock); while (!arvalid);
				addr = ar.addr;
				@(posedge clock);
				#2;
				arready = 1'b0;
				delay = take_bits(2);
				repeat (delay) begin
					@(posedge clock);
					#2;
				end
				r.data = {~addr, addr};
				r.resp = resp_okay;
				rvalid = 1'b1;
				do @(negedge clock); while (!rready);
				@(posedge clock);
				#2;
				rvalid = 1'b0;
			end
		end
	end

	// write side
	initial begin
		logic got_aw;
		logic got_w;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = 2'b00;
		last_awaddr = 32'h0;
		last_wdata = 64'h0;
		last_wstrb = 8'h0;
		last_wlast = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			if (!rst) begin
				awready = 1'b1;
				wready = 1'b1;
				got_aw = 1'b0;
				got_w = 1'b0;
				while (!(got_aw && got_w)) begin
					@(negedge clock);
					if (awvalid && awready) begin
						last_awaddr = aw.addr;
						got_aw = 1'b1;
					end
					if (wvalid && wready) begin
						last_wdata = w.data;
						last_wstrb = w.strb;
						last_wlast = wlast;
						got_w = 1'b1;
					end
					@(posedge clock);
					#2;
					if (got_aw) awready = 1'b0;
					if (got_w) wready = 1'b0;
				end
				bresp = resp_okay;
				bvalid = 1'b1;
				do @(negedge clock); while (!bready);
				@(posedge clock);
				#2;
				bvalid = 1'b0;
			end
		end
	end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;    // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (16) @(posedge clock);
		#2;
		rst = 1'b0;
	end

endmodule

//--- verilog/uncore_top.sv
`timescale 1ns/100ps

module uncore_top #(
	parameter logic [31:0] clint_base = 32'h0200_0000,
	parameter logic [31:0] clint_mask = 32'h0000_ffff
) (
	input  logic                clock,
	input  logic                rst,

	input  xbar_pkg::addr_req_t ifu_ar,
	input  logic                ifu_arvalid,
	output logic                ifu_arready,
	output logic [31:0]         ifu_rdata,
	output logic [1:0]          ifu_rresp,
	output logic                ifu_rvalid,
	input  logic                ifu_rready,

	input  xbar_pkg::addr_req_t lsu_ar,
	input  logic                lsu_arvalid,
	output logic                lsu_arready,
	output xbar_pkg::r_resp_t   lsu_r,
	output logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  xbar_pkg::addr_req_t lsu_aw,
	input  logic                lsu_awvalid,
	output logic                lsu_awready,
	input  logic [31:0]         lsu_wdata,
	input  logic [7:0]          lsu_wstrb,
	input  logic                lsu_wvalid,
	output logic                lsu_wready,
	output logic [1:0]          lsu_bresp,
	output logic                lsu_bvalid,
	input  logic                lsu_bready,

	output xbar_pkg::addr_req_t soc_ar,
	output logic                soc_arvalid,
	input  logic                soc_arready,
	input  xbar_pkg::r_resp_t   soc_r,
	input  logic                soc_rvalid,
	output logic                soc_rready,
	output xbar_pkg::addr_req_t soc_aw,
	output logic                soc_awvalid,
	input  logic                soc_awready,
	output xbar_pkg::w_beat_t   soc_w,
	output logic                soc_wlast,
	output logic                soc_wvalid,
	input  logic                soc_wready,
	input  logic [1:0]          soc_bresp,
	input  logic                soc_bvalid,
	output logic                soc_bready
);

	import xbar_pkg::*;

	addr_req_t clint_ar;
	logic      clint_arvalid;
	logic      clint_arready;
	r_resp_t   clint_r;
	logic      clint_rvalid;
	logic      clint_rready;

	xbar #(
		.clint_base (clint_base),
		.clint_mask (clint_mask)
	) xbar_i (
		.clock         (clock),
		.rst           (rst),
		.ifu_ar        (ifu_ar),
		.ifu_arvalid   (ifu_arvalid),
		.ifu_arready   (ifu_arready),
		.ifu_rdata     (ifu_rdata),
		.ifu_rresp     (ifu_rresp),
		.ifu_rvalid    (ifu_rvalid),
		.ifu_rready    (ifu_rready),
		.lsu_ar        (lsu_ar),
		.lsu_arvalid   (lsu_arvalid),
		.lsu_arready   (lsu_arready),
		.lsu_r         (lsu_r),
		.lsu_rvalid    (lsu_rvalid),
		.lsu_rready    (lsu_rready),
		.lsu_aw        (lsu_aw),
		.lsu_awvalid   (lsu_awvalid),
		.lsu_awready   (lsu_awready),
		.lsu_wdata     (lsu_wdata),
		.lsu_wstrb     (lsu_wstrb),
		.lsu_wvalid    (lsu_wvalid),
		.lsu_wready    (lsu_wready),
		.lsu_bresp     (lsu_bresp),
		.lsu_bvalid    (lsu_bvalid),
		.lsu_bready    (lsu_bready),
		.soc_ar        (soc_ar),
		.soc_arvalid   (soc_arvalid),
		.soc_arready   (soc_arready),
		.soc_r         (soc_r),
		.soc_rvalid    (soc_rvalid),
		.soc_rready    (soc_rready),
		.soc_aw        (soc_aw),
		.soc_awvalid   (soc_awvalid),
		.soc_awready   (soc_awready),
		.soc_w         (soc_w),
		.soc_wlast     (soc_wlast),
		.soc_wvalid    (soc_wvalid),
		.soc_wready    (soc_wready),
		.soc_bresp     (soc_bresp),
		.soc_bvalid    (soc_bvalid),
		.soc_bready    (soc_bready),
		.clint_ar      (clint_ar),
		.clint_arvalid (clint_arvalid),
		.clint_arready (clint_arready),
		.clint_r       (clint_r),
		.clint_rvalid  (clint_rvalid),
		.clint_rready  (clint_rready)
	);

	clint #(
		.clint_base (clint_base)
	) clint_i (
		.clock   (clock),
		.rst     (rst),
		.ar      (clint_ar),
		.arvalid (clint_arvalid),
		.arready (clint_arready),
		.r       (clint_r),
		.rvalid  (clint_rvalid),
		.rready  (clint_rready)
	);

endmodule

//--- verilog/xbar.sv
`timescale 1ns/100ps

module xbar #(
	parameter logic [31:0] clint_base = 32'h0200_0000,
	parameter logic [31:0] clint_mask = 32'h0000_ffff
) (
	input  logic                clock,
	input  logic                rst,

	input  xbar_pkg::addr_req_t ifu_ar,
	input  logic                ifu_arvalid,
	output logic                ifu_arready,
	output logic [31:0]         ifu_rdata,
	output logic [1:0]          ifu_rresp,
	output logic                ifu_rvalid,
	input  logic                ifu_rready,

	input  xbar_pkg::addr_req_t lsu_ar,
	input  logic                lsu_arvalid,
	output logic                lsu_arready,
	output xbar_pkg::r_resp_t   lsu_r,
	output logic                lsu_rvalid,
	input  logic                lsu_rready,
	input  xbar_pkg::addr_req_t lsu_aw,
	input  logic                lsu_awvalid,
	output logic                lsu_awready,
	input  logic [31:0]         lsu_wdata,
	input  logic [7:0]          lsu_wstrb,
	input  logic                lsu_wvalid,
	output logic                lsu_wready,
	output logic [1:0]          lsu_bresp,
	output logic                lsu_bvalid,
	input  logic                lsu_bready,

	output xbar_pkg::addr_req_t soc_ar,
	output logic                soc_arvalid,
	input  logic                soc_arready,
	input  xbar_pkg::r_resp_t   soc_r,
	input  logic                soc_rvalid,
	output logic                soc_rready,
	output xbar_pkg::addr_req_t soc_aw,
	output logic                soc_awvalid,
	input  logic                soc_awready,
	output xbar_pkg::w_beat_t   soc_w,
	output logic                soc_wlast,
	output logic                soc_wvalid,
	input  logic                soc_wready,
	input  logic [1:0]          soc_bresp,
	input  logic                soc_bvalid,
	output logic                soc_bready,

	output xbar_pkg::addr_req_t clint_ar,
	output logic                clint_arvalid,
	input  logic                clint_arready,
	input  xbar_pkg::r_resp_t   clint_r,
	input  logic                clint_rvalid,
	output logic                clint_rready
);

	logic grant_ifu;
	logic grant_lsu;
	logic lsu_soc_arvalid;    // router's share of the soc read port
	logic lsu_soc_rready;

	read_arbiter arb_i (
		.clock       (clock),
		.rst         (rst),
		.ifu_arvalid (ifu_arvalid),
		.lsu_arvalid (lsu_arvalid),
		.ifu_rhs     (ifu_rvalid & ifu_rready),
		.lsu_rhs     (lsu_rvalid & lsu_rready),
		.grant_ifu   (grant_ifu),
		.grant_lsu   (grant_lsu)
	);

	addr_router #(
		.clint_base (clint_base),
		.clint_mask (clint_mask)
	) router_i (
		.clock         (clock),
		.rst           (rst),
		.grant_lsu     (grant_lsu),
		.lsu_ar        (lsu_ar),
		.lsu_arvalid   (lsu_arvalid),
		.lsu_arready   (lsu_arready),
		.lsu_r         (lsu_r),
		.lsu_rvalid    (lsu_rvalid),
		.lsu_rready    (lsu_rready),
		.soc_ar_valid  (lsu_soc_arvalid),
		.soc_ar_ready  (soc_arready),
		.soc_r         (soc_r),
		.soc_r_valid   (soc_rvalid),
		.soc_r_ready   (lsu_soc_rready),
		.clint_ar      (clint_ar),
		.clint_arvalid (clint_arvalid),
		.clint_arready (clint_arready),
		.clint_r       (clint_r),
		.clint_rvalid  (clint_rvalid),
		.clint_rready  (clint_rready)
	);

	// soc read port merged by grant
	assign soc_ar      = grant_ifu ? ifu_ar : lsu_ar;
	assign soc_arvalid = (grant_ifu & ifu_arvalid) | lsu_soc_arvalid;
	assign soc_rready  = (grant_ifu & ifu_rready) | lsu_soc_rready;

	assign ifu_arready = grant_ifu & soc_arready;
	assign ifu_rvalid  = grant_ifu & soc_rvalid;
	assign ifu_rdata   = soc_r.data[31:0];    // instructions sit in the low half
	assign ifu_rresp   = soc_r.resp;

	// writes go straight to the soc port
	assign soc_aw      = lsu_aw;
	assign soc_awvalid = lsu_awvalid;
	assign lsu_awready = soc_awready;

	assign soc_w.data  = {32'h0, lsu_wdata};
	assign soc_w.strb  = lsu_wstrb;
	assign soc_wvalid  = lsu_wvalid;
	assign soc_wlast   = lsu_wvalid;    // single beat
	assign lsu_wready  = soc_wready;

	assign lsu_bresp  = soc_bresp;
	assign lsu_bvalid = soc_bvalid;
	assign soc_bready = lsu_bready;

endmodule

//--- verilog/clint.sv
`timescale 1ns/100ps

module clint #(
	parameter logic [31:0] clint_base = 32'h0200_0000
) (
	input  logic                clock,
	input  logic                rst,

	input  xbar_pkg::addr_req_t ar,
	input  logic                arvalid,
	output logic                arready,

	output xbar_pkg::r_resp_t   r,
	output logic                rvalid,
	input  logic                rready
);

	import xbar_pkg::*;

	localparam logic [31:0] mtime_lo = 32'h0000_bff8;
	localparam logic [31:0] mtime_hi = 32'h0000_bffc;

	logic [63:0] mtime;
	logic [31:0] offset;

	assign offset  = ar.addr - clint_base;
	assign arready = ~rvalid;    // one response at a time

	// free running with no compare or interrupt
	always_ff @(posedge clock) begin
		if (rst) begin
			mtime <= 64'h0;
		end else begin
			mtime <= mtime + 64'h1;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (arvalid && arready) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// response payload held until rready
	always_ff @(posedge clock) begin
		if (arvalid && arready) begin
			case (offset)
				mtime_lo: begin
					r.data <= {32'h0, mtime[31:0]};
					r.resp <= resp_okay;
				end
				mtime_hi: begin
					r.data <= {32'h0, mtime[63:32]};
					r.resp <= resp_okay;
				end
				default: begin
					r.data <= 64'h0;
					r.resp <= resp_slverr;    // unmapped offset
				end
			endcase
		end
	end

endmodule

//--- verilog/addr_router.sv
`timescale 1ns/100ps

module addr_router #(
	parameter logic [31:0] clint_base = 32'h0200_0000,
	parameter logic [31:0] clint_mask = 32'h0000_ffff
) (
	input  logic                clock,
	input  logic                rst,
	input  logic                grant_lsu,

	input  xbar_pkg::addr_req_t lsu_ar,
	input  logic                lsu_arvalid,
	output logic                lsu_arready,
	output xbar_pkg::r_resp_t   lsu_r,
	output logic                lsu_rvalid,
	input  logic                lsu_rready,

	output logic                soc_ar_valid,
	input  logic                soc_ar_ready,
	input  xbar_pkg::r_resp_t   soc_r,
	input  logic                soc_r_valid,
	output logic                soc_r_ready,

	output xbar_pkg::addr_req_t clint_ar,
	output logic                clint_arvalid,
	input  logic                clint_arready,
	input  xbar_pkg::r_resp_t   clint_r,
	input  logic                clint_rvalid,
	output logic                clint_rready
);

	logic hit_clint;    // live decode of lsu_ar
	logic tgt_clint;    // target captured at ar handshake
	logic ar_done;
	logic sel_clint;

	assign hit_clint = (lsu_ar.addr & ~clint_mask) == clint_base;
	assign sel_clint = ar_done ? tgt_clint : hit_clint;

	// address side closes once the request is taken
	assign clint_ar      = lsu_ar;
	assign clint_arvalid = grant_lsu & ~ar_done & hit_clint & lsu_arvalid;
	assign soc_ar_valid  = grant_lsu & ~ar_done & ~hit_clint & lsu_arvalid;
	assign lsu_arready   = grant_lsu & ~ar_done & (hit_clint ? clint_arready : soc_ar_ready);

	assign lsu_r        = sel_clint ? clint_r : soc_r;
	assign lsu_rvalid   = grant_lsu & (sel_clint ? clint_rvalid : soc_r_valid);
	assign clint_rready = grant_lsu & sel_clint & lsu_rready;
	assign soc_r_ready  = grant_lsu & ~sel_clint & lsu_rready;

	always_ff @(posedge clock) begin
		if (rst) begin
			ar_done <= 1'b0;
		end else if (lsu_arvalid && lsu_arready) begin
			ar_done <= 1'b1;
		end else if (lsu_rvalid && lsu_rready) begin
			ar_done <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (lsu_arvalid && lsu_arready) begin
			tgt_clint <= hit_clint;
		end
	end

endmodule

//--- verilog/read_arbiter.sv
`timescale 1ns/100ps

module read_arbiter (
	input  logic clock,
	input  logic rst,

	input  logic ifu_arvalid,
	input  logic lsu_arvalid,

	input  logic ifu_rhs,    // r handshake seen by ifu
	input  logic lsu_rhs,    // r handshake seen by lsu

	output logic grant_ifu,
	output logic grant_lsu
);

	localparam logic [1:0] st_idle = 2'b00;
	localparam logic [1:0] st_ifu  = 2'b01;
	localparam logic [1:0] st_lsu  = 2'b10;

	logic [1:0] state;
	logic [1:0] state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (ifu_arvalid) begin
					state_nxt = st_ifu;    // ifu wins a tie
				end else if (lsu_arvalid) begin
					state_nxt = st_lsu;
				end
			end
			st_ifu: begin
				if (ifu_rhs) begin
					state_nxt = st_idle;
				end
			end
			st_lsu: begin
				if (lsu_rhs) begin
					state_nxt = st_idle;
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// each one-hot state bit is a grant
	assign grant_ifu = state[0];
	assign grant_lsu = state[1];

endmodule

//--- verilog/xbar_pkg.sv
package xbar_pkg;

	// address request for ar and aw
	typedef struct packed {
		logic [31:0] addr;
		logic [2:0]  size;
	} addr_req_t;

	// read response beat
	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
	} r_resp_t;

	// soc side write beat
	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  strb;
	} w_beat_t;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage
